// File: design/emesh_arb_pkg.sv
`default_nettype none
`include "emesh_params.svh"

// ####################################################################
// Arbitration types shared by arbiter, mux and top
// ####################################################################
package emesh_arb_pkg;

   // Grant policy, a level input sampled every cycle
   typedef enum logic
   {
      ARB_STATIC      = 1'b0,
      ARB_ROUND_ROBIN = 1'b1
   } arb_mode_t;

   // Index of one input channel
   typedef logic [$clog2(`EMESH_N)-1:0] chan_t;

endpackage

`default_nettype wire

// File: design/emesh_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "emesh_params.svh"

// ####################################################################
// One-hot arbiter, fixed priority or round robin
// ####################################################################
module emesh_arbiter
(
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic [`EMESH_N-1:0]       requests,
   input  wire emesh_arb_pkg::arb_mode_t  mode,
   input  wire logic                      advance,
   output logic [`EMESH_N-1:0]            grants,
   output emesh_arb_pkg::chan_t           grant_idx
);

   localparam int N = `EMESH_N;

   // Highest channel index, wrap point of the pointer
   localparam emesh_arb_pkg::chan_t LAST_IDX = emesh_arb_pkg::chan_t'(N - 1);

   // Round-robin pointer, first channel searched
   emesh_arb_pkg::chan_t pointer;

   // Start of the search for this cycle
   emesh_arb_pkg::chan_t search_base;

   // Channel just after the current winner
   emesh_arb_pkg::chan_t next_pointer;

   // Static mode always searches from channel 0
   assign search_base = (mode == emesh_arb_pkg::ARB_ROUND_ROBIN) ? pointer : '0;

   // ####################################################################
   // Circular search from search_base
   // ####################################################################

   always_comb
   begin
      int   idx;
      logic found;
      grants    = '0;
      grant_idx = '0;
      found     = 1'b0;
      idx       = 0;
      for (int k = 0; k < N; k++)
      begin
         idx = (int'(search_base) + k) % N;
         // First requester in circular order wins
         if (!found && requests[idx])
         begin
            found       = 1'b1;
            grants[idx] = 1'b1;
            grant_idx   = emesh_arb_pkg::chan_t'(idx);
         end
      end
   end

   // ####################################################################
   // Pointer update
   // ####################################################################

   assign next_pointer = (grant_idx == LAST_IDX) ? '0 : grant_idx + 1'b1;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pointer <= '0;
      end
      else if (advance && (mode == emesh_arb_pkg::ARB_ROUND_ROBIN))
      begin
         // Winner drops to lowest priority
         pointer <= next_pointer;
      end
   end

   // ####################################################################
   // Checks
   // ####################################################################

   a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(grants))
      else $error("emesh_arbiter: more than one grant");

   a_grant_when_request : assert property (@(posedge clk) disable iff (!rst_n)
      (|requests) |-> (|grants))
      else $error("emesh_arbiter: requests pending without a grant");

endmodule

`default_nettype wire

// File: design/emesh_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "emesh_params.svh"

// ####################################################################
// N-to-1 emesh merge: input slices, mux, tagged output slice
// ####################################################################
module emesh_merge
(
   input  wire logic                      clk,
   input  wire logic                      rst_n,

   // Input channels
   input  wire logic [`EMESH_N-1:0]       access_in,
   input  wire emesh_pkg::packet_t        packet_in [`EMESH_N],
   output logic [`EMESH_N-1:0]            ready_out,

   // Merged output channel
   input  wire logic                      ready_in,
   output logic                           access_out,
   output emesh_pkg::packet_t             packet_out,
   output emesh_arb_pkg::chan_t           src_out,

   // Change only while all channels are idle
   input  wire emesh_arb_pkg::arb_mode_t  arb_mode
);

   // Input slices toward the mux
   wire logic [`EMESH_N-1:0]  in_access;
   wire emesh_pkg::packet_t   in_packet [`EMESH_N];
   wire logic [`EMESH_N-1:0]  mux_ready;

   // Mux toward the output slice
   wire logic                 mux_access;
   wire emesh_pkg::packet_t   mux_packet;
   wire emesh_arb_pkg::chan_t mux_src;
   wire logic                 out_ready;

   // Tagged payload in and out of the output slice
   wire emesh_pkg::tagged_t   mux_tagged;
   wire emesh_pkg::tagged_t   out_tagged;

   // ####################################################################
   // Input slices
   // ####################################################################

   for (genvar i = 0; i < `EMESH_N; i++)
   begin : g_in_slice
      emesh_slice #(.payload_t(emesh_pkg::packet_t)) u_in_slice
      (
         .clk        (clk),
         .rst_n      (rst_n),
         .access_in  (access_in[i]),
         .packet_in  (packet_in[i]),
         .ready_out  (ready_out[i]),
         .ready_in   (mux_ready[i]),
         .access_out (in_access[i]),
         .packet_out (in_packet[i])
      );
   end

   // ####################################################################
   // Arbitrating mux
   // ####################################################################

   emesh_mux u_mux
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (in_access),
      .packet_in  (in_packet),
      .ready_out  (mux_ready),
      .ready_in   (out_ready),
      .access_out (mux_access),
      .packet_out (mux_packet),
      .src_out    (mux_src),
      .mode       (arb_mode)
   );

   // ####################################################################
   // Output slice
   // ####################################################################

   // Packet in the upper bits, tag at the bottom
   assign mux_tagged = {mux_packet, mux_src};

   emesh_slice #(.payload_t(emesh_pkg::tagged_t)) u_out_slice
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (mux_access),
      .packet_in  (mux_tagged),
      .ready_out  (out_ready),
      .ready_in   (ready_in),
      .access_out (access_out),
      .packet_out (out_tagged)
   );

   assign packet_out = out_tagged.pkt;
   assign src_out    = out_tagged.src;

endmodule

`default_nettype wire

// File: design/emesh_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "emesh_params.svh"

// ####################################################################
// Grant-driven packet multiplexer
// ####################################################################
module emesh_mux
(
   input  wire logic                      clk,
   input  wire logic                      rst_n,

   // Incoming transactions
   input  wire logic [`EMESH_N-1:0]       access_in,
   input  wire emesh_pkg::packet_t        packet_in [`EMESH_N],
   output logic [`EMESH_N-1:0]            ready_out,

   // Outgoing transaction
   input  wire logic                      ready_in,
   output logic                           access_out,
   output emesh_pkg::packet_t             packet_out,
   output emesh_arb_pkg::chan_t           src_out,

   // Grant policy
   input  wire emesh_arb_pkg::arb_mode_t  mode
);

   localparam int N  = `EMESH_N;
   localparam int PW = `EMESH_PW;

   logic [N-1:0]         grants;
   emesh_arb_pkg::chan_t grant_idx;

   // Output transfer this cycle
   logic advance;

   // OR-reduced granted packet
   logic [PW-1:0] packet_or;

   // ####################################################################
   // Arbiter
   // ####################################################################

   emesh_arbiter u_arbiter
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .requests  (access_in),
      .mode      (mode),
      .advance   (advance),
      .grants    (grants),
      .grant_idx (grant_idx)
   );

   // Any request makes an outgoing access
   assign access_out = |access_in;

   // Rotate only when a packet really leaves
   assign advance = access_out & ready_in;

   // Blocked requesters see ready low
   // Idle and granted channels follow ready_in
   assign ready_out = ~(access_in & ~grants) & {N{ready_in}};

   // Source tag straight from the winner
   assign src_out = grant_idx;

   // ####################################################################
   // AND-OR packet select
   // ####################################################################

   always_comb
   begin
      packet_or = '0;
      for (int i = 0; i < N; i++)
      begin
         packet_or = packet_or | ({PW{grants[i]}} & packet_in[i]);
      end
   end

   assign packet_out = packet_or;

endmodule

`default_nettype wire

// File: design/emesh_params.svh
`ifndef EMESH_PARAMS_SVH
`define EMESH_PARAMS_SVH

// ####################################################################
// Build-wide sizing of the emesh merge stage
// ####################################################################

// Address width of one emesh transaction
`define EMESH_AW 32

// Full packet width
// Control byte plus three address-wide words
`define EMESH_PW (2 * `EMESH_AW + 40)

// Input channels feeding the merge
`define EMESH_N 4

`endif

// File: design/emesh_pkg.sv
`default_nettype none
`include "emesh_params.svh"

// ####################################################################
// Emesh packet layout
// ####################################################################
package emesh_pkg;

   localparam int AW         = `EMESH_AW;
   localparam int WRITE_W    = 1;
   localparam int DATAMODE_W = 2;
   localparam int CTRLMODE_W = 5;

   // Fields listed MSB first
   // Write strobe ends up at bit 0, srcaddr in the top word
   // Fields fill the packet exactly at AW of 32, so no pad word is left
   typedef struct packed
   {
      logic [AW-1:0]         srcaddr;
      logic [AW-1:0]         data;
      logic [AW-1:0]         dstaddr;
      logic [CTRLMODE_W-1:0] ctrlmode;
      logic [DATAMODE_W-1:0] datamode;
      logic [WRITE_W-1:0]    write;
   } packet_t;

   // ####################################################################
   // Output payload with source tag
   // ####################################################################

   // Packet plus the channel it came from
   typedef struct packed
   {
      packet_t              pkt;
      emesh_arb_pkg::chan_t src;
   } tagged_t;

endpackage

`default_nettype wire

// File: design/emesh_slice.sv
`timescale 1ns/1ps
`default_nettype none

// ####################################################################
// Single-entry access/ready register stage
// ####################################################################
module emesh_slice
#(
   parameter type payload_t = logic
)
(
   input  wire logic     clk,
   input  wire logic     rst_n,

   // Upstream side
   input  wire logic     access_in,
   input  wire payload_t packet_in,
   output logic          ready_out,

   // Downstream side
   input  wire logic     ready_in,
   output logic          access_out,
   output payload_t      packet_out
);

   // Entry valid flag
   logic full;

   // Held payload
   payload_t entry;

   // Accept when empty or when the entry leaves this cycle
   // Combinational path from ready_in
   assign ready_out = ~full | ready_in;

   // ####################################################################
   // Control state
   // ####################################################################

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         full <= 1'b0;
      end
      else if (ready_out)
      begin
         // Refill or drain in the same edge
         full <= access_in;
      end
   end

   // ####################################################################
   // Payload register
   // ####################################################################

   always_ff @(posedge clk)
   begin
      if (ready_out)
      begin
         entry <= packet_in;
      end
   end

   // Outputs straight from the register
   assign access_out = full;
   assign packet_out = entry;

   // ####################################################################
   // Checks
   // ####################################################################

   // Stalled entry stays put until the downstream takes it
   property p_hold_when_stalled;
      @(posedge clk) disable iff (!rst_n)
         (full && !ready_in) |=> (access_out && $stable(packet_out));
   endproperty

   a_hold_when_stalled : assert property (p_hold_when_stalled)
      else $error("emesh_slice: entry changed under back-pressure");

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_emesh_merge -o sim_emesh_merge

output="$(./obj_dir/sim_emesh_merge)"
echo "$output"

if echo "$output" | grep -q "^STATUS: PASS$"; then
   exit 0
else
   exit 1
fi

// File: sim/emesh_merge_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "emesh_params.svh"

// ####################################################################
// Scoreboard for the merge stage, samples everything at the rising edge
// ####################################################################
module emesh_merge_checker
(
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic [`EMESH_N-1:0]       access_in,
   input  wire emesh_pkg::packet_t        packet_in [`EMESH_N],
   input  wire logic [`EMESH_N-1:0]       ready_out,
   input  wire logic                      ready_in,
   input  wire logic                      access_out,
   input  wire emesh_pkg::packet_t        packet_out,
   input  wire emesh_arb_pkg::chan_t      src_out,
   input  wire emesh_arb_pkg::arb_mode_t  arb_mode,

   // Test control from the testbench top
   input  int                             test_num,
   input  wire logic                      window,
   input  wire logic                      end_test,
   output int                             pending,
   output int                             errors,
   output int                             tests_passed,
   output int                             tests_failed
);

   localparam int N = `EMESH_N;

   // Expected packets per source channel, in arrival order
   emesh_pkg::packet_t exp_q [N][$];

   // Output seen stalled at the previous edge
   logic                 held;
   emesh_pkg::packet_t   held_packet;
   emesh_arb_pkg::chan_t held_src;

   // Previous source inside the round-robin window
   logic                 have_last;
   emesh_arb_pkg::chan_t last_src;

   int test_errors;

   function automatic string test_name(int n);
      case (n)
         1: return "reset_state";
         2: return "static_random";
         3: return "backpressure_hold";
         4: return "static_priority";
         5: return "rr_fairness";
         6: return "rr_random";
         default: return "no_test";
      endcase
   endfunction

   task automatic report_value(string what, logic [127:0] expected, logic [127:0] actual);
      $display("FAILED %s %s: expected %0h actual %0h",
               test_name(test_num), what, expected, actual);
      errors++;
      test_errors++;
   endtask

   task automatic report_text(string text);
      $display("ERROR in %s: %s", test_name(test_num), text);
      errors++;
      test_errors++;
   endtask

   // ####################################################################
   // Per-edge checks
   // ####################################################################

   always @(posedge clk)
   begin
      emesh_pkg::packet_t expected;
      if (!rst_n)
      begin
         held      = 1'b0;
         have_last = 1'b0;
      end
      else
      begin
         // Idle state straight out of reset
         if (test_num == 1)
         begin
            if (access_out !== 1'b0)
               report_value("access_out", 128'(1'b0), 128'(access_out));
            if (ready_out !== {N{1'b1}})
               report_value("ready_out", 128'({N{1'b1}}), 128'(ready_out));
         end

         // Input transfers feed the model
         for (int i = 0; i < N; i++)
         begin
            if (access_in[i] && ready_out[i])
            begin
               exp_q[i].push_back(packet_in[i]);
               pending++;
            end
         end

         // Stalled output must not move
         if (held)
         begin
            if (!access_out)
               report_text("access_out dropped while the output was stalled");
            if (packet_out !== held_packet)
               report_value("held packet_out", 128'(held_packet), 128'(packet_out));
            if (src_out !== held_src)
               report_value("held src_out", 128'(held_src), 128'(src_out));
         end
         held        = access_out && !ready_in;
         held_packet = packet_out;
         held_src    = src_out;

         // Output transfer pops the source queue
         if (access_out && ready_in)
         begin
            if (exp_q[src_out].size() == 0)
            begin
               report_text($sformatf("output tagged channel %0d with no packet expected",
                                     src_out));
            end
            else
            begin
               expected = exp_q[src_out].pop_front();
               pending--;
               if (packet_out !== expected)
                  report_value($sformatf("packet_out ch%0d", src_out),
                               128'(expected), 128'(packet_out));
            end

            // Lowest index always wins when saturated
            if (window && arb_mode == emesh_arb_pkg::ARB_STATIC && src_out != 0)
               report_value("src_out", 128'(0), 128'(src_out));

            // Strict rotation, one channel per transfer
            if (window && arb_mode == emesh_arb_pkg::ARB_ROUND_ROBIN)
            begin
               if (have_last && int'(src_out) != (int'(last_src) + 1) % N)
                  report_value("src_out", 128'((int'(last_src) + 1) % N), 128'(src_out));
               have_last = 1'b1;
               last_src  = src_out;
            end
         end
         if (!window)
            have_last = 1'b0;

         // Test wrap-up, leftovers mean lost packets
         if (end_test)
         begin
            if (pending != 0)
            begin
               report_text($sformatf("%0d accepted packets never came out", pending));
               for (int i = 0; i < N; i++)
                  exp_q[i].delete();
               pending = 0;
            end
            $display("Test %0d %s: %s (%0d errors)", test_num, test_name(test_num),
                     (test_errors == 0) ? "passed" : "failed", test_errors);
            if (test_errors == 0)
               tests_passed++;
            else
               tests_failed++;
            test_errors = 0;
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/tb_emesh_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "emesh_params.svh"

module tb_emesh_merge;

   localparam int N           = `EMESH_N;
   localparam int PKTS        = 90;
   localparam int PKTS_BP     = 25;
   localparam int SAT_CYCLES  = 40;
   localparam int DRAIN_LIMIT = 30;
   localparam int NUM_TESTS   = 6;

   // About 2 cycles per packet at 75% ready, 4 at 30%, plus saturated runs
   localparam int EST_CYCLES = 2 * (2 * N * PKTS) + 4 * N * PKTS_BP
                               + 2 * (SAT_CYCLES + DRAIN_LIMIT) + 20;
   localparam int MAX_CYCLES = 2 * EST_CYCLES;

   logic                     clk;
   logic                     rst_n;
   logic [N-1:0]             access_in;
   emesh_pkg::packet_t       packet_in [N];
   logic [N-1:0]             ready_out;
   logic                     ready_in;
   logic                     access_out;
   emesh_pkg::packet_t       packet_out;
   emesh_arb_pkg::chan_t     src_out;
   emesh_arb_pkg::arb_mode_t arb_mode;

   // Scoreboard control and results
   int   test_num;
   logic window;
   logic end_test;
   int   pending;
   int   errors;
   int   tests_passed;
   int   tests_failed;

   // Sender state
   emesh_pkg::packet_t stim_q [N][$];
   int                 gap_cnt [N];
   int                 gap_max;
   int                 ready_pct;
   logic [N-1:0]       took;
   int                 cycles;

   emesh_merge DUT
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .ready_out  (ready_out),
      .ready_in   (ready_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .src_out    (src_out),
      .arb_mode   (arb_mode)
   );

   emesh_merge_checker u_checker
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .access_in    (access_in),
      .packet_in    (packet_in),
      .ready_out    (ready_out),
      .ready_in     (ready_in),
      .access_out   (access_out),
      .packet_out   (packet_out),
      .src_out      (src_out),
      .arb_mode     (arb_mode),
      .test_num     (test_num),
      .window       (window),
      .end_test     (end_test),
      .pending      (pending),
      .errors       (errors),
      .tests_passed (tests_passed),
      .tests_failed (tests_failed)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Offers taken at this edge
   always @(posedge clk)
   begin
      took <= access_in & ready_out;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: the run made no finish within %0d cycles", MAX_CYCLES);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // ####################################################################
   // Stimulus helpers
   // ####################################################################

   // Everything below drives at the falling edge

   function automatic emesh_pkg::packet_t new_packet();
      logic [127:0] raw;
      raw = {$urandom(), $urandom(), $urandom(), $urandom()};
      return emesh_pkg::packet_t'(raw[`EMESH_PW-1:0]);
   endfunction

   function automatic logic stim_idle();
      logic idle;
      idle = (access_in == '0);
      for (int c = 0; c < N; c++)
         if (stim_q[c].size() != 0)
            idle = 1'b0;
      return idle;
   endfunction

   task automatic drive_channels();
      for (int c = 0; c < N; c++)
      begin
         // Offer accepted at the last rising edge
         if (access_in[c] && took[c])
            access_in[c] = 1'b0;
         if (!access_in[c])
         begin
            if (gap_cnt[c] > 0)
               gap_cnt[c]--;
            else if (stim_q[c].size() != 0)
            begin
               packet_in[c] = stim_q[c].pop_front();
               access_in[c] = 1'b1;
               gap_cnt[c]   = $urandom_range(gap_max, 0);
            end
         end
      end
      ready_in = ($urandom_range(99, 0) < ready_pct);
   endtask

   task automatic step();
      @(negedge clk);
      drive_channels();
   endtask

   // Drain the DUT, then let the scoreboard close the test
   task automatic finish_test();
      int k;
      ready_pct = 100;
      k = 0;
      while (pending != 0 && k < DRAIN_LIMIT)
      begin
         step();
         k++;
      end
      end_test = 1'b1;
      step();
      end_test = 1'b0;
   endtask

   task automatic run_random(int test, int count, int gap, int pct,
                             emesh_arb_pkg::arb_mode_t mode);
      test_num  = test;
      arb_mode  = mode;
      gap_max   = gap;
      ready_pct = pct;
      for (int c = 0; c < N; c++)
         for (int k = 0; k < count; k++)
            stim_q[c].push_back(new_packet());
      while (!stim_idle())
         step();
      finish_test();
   endtask

   // All channels busy with ready_in high
   // Grant order is checked only inside the window
   task automatic run_saturated(int test, emesh_arb_pkg::arb_mode_t mode);
      test_num  = test;
      arb_mode  = mode;
      gap_max   = 0;
      ready_pct = 100;
      for (int c = 0; c < N; c++)
         for (int k = 0; k < SAT_CYCLES; k++)
            stim_q[c].push_back(new_packet());
      repeat (4) step();
      window = 1'b1;
      repeat (SAT_CYCLES - 8) step();
      window = 1'b0;
      // Senders still finish the packet they hold
      for (int c = 0; c < N; c++)
         stim_q[c].delete();
      while (!stim_idle())
         step();
      finish_test();
   endtask

   // ####################################################################
   // Test sequence
   // ####################################################################

   initial
   begin
      void'($urandom(5029));
      rst_n     = 1'b0;
      access_in = '0;
      ready_in  = 1'b0;
      arb_mode  = emesh_arb_pkg::ARB_STATIC;
      for (int c = 0; c < N; c++)
      begin
         packet_in[c] = '0;
         gap_cnt[c]   = 0;
      end
      test_num  = 1;
      window    = 1'b0;
      end_test  = 1'b0;
      gap_max   = 0;
      ready_pct = 100;

      // Reset low for five rising edges
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (2) step();
      finish_test();

      run_random(2, PKTS, 3, 75, emesh_arb_pkg::ARB_STATIC);
      run_random(3, PKTS_BP, 2, 30, emesh_arb_pkg::ARB_STATIC);
      run_saturated(4, emesh_arb_pkg::ARB_STATIC);
      run_saturated(5, emesh_arb_pkg::ARB_ROUND_ROBIN);
      run_random(6, PKTS, 3, 75, emesh_arb_pkg::ARB_ROUND_ROBIN);

      $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0 && tests_passed == NUM_TESTS)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/emesh_arb_pkg.sv
design/emesh_pkg.sv
design/emesh_slice.sv
design/emesh_arbiter.sv
design/emesh_mux.sv
design/emesh_merge.sv
sim/emesh_merge_checker.sv
sim/tb_emesh_merge.sv
